// File: common/core_settings.svh
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// ==================================================================
// core sizing
// ==================================================================

// data and address width
`define CORE_XLEN 32

// integer register count, x0 included
`define CORE_NREGS 32

// first fetch address after reset
`define CORE_RESET_PC 32'h0000_0000

`endif

// File: common/core_pkg.sv
`default_nettype none

package core_pkg;

    // major rv32i opcodes
    typedef enum logic [6:0] {
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_branch = 7'b1100011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_imm    = 7'b0010011,
        op_reg    = 7'b0110011,
        op_fence  = 7'b0001111,
        op_system = 7'b1110011
    } opcode_t;

    // ==================================================================
    // instruction formats
    // ==================================================================

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_t    opcode;
    } instr_r_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_t     opcode;
    } instr_i_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        opcode_t    opcode;
    } instr_s_t;

    // branch offset is scattered, bit 0 implied
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        opcode_t    opcode;
    } instr_b_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        opcode_t     opcode;
    } instr_u_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        opcode_t    opcode;
    } instr_j_t;

    // one fetched word, six views
    typedef union packed {
        instr_r_t r;
        instr_i_t i;
        instr_s_t s;
        instr_b_t b;
        instr_u_t u;
        instr_j_t j;
    } instr_t;

    // what the controller has to do with it
    typedef enum logic [3:0] {
        cls_lui, cls_auipc, cls_jal, cls_jalr, cls_branch,
        cls_load, cls_store, cls_alu, cls_nop
    } instr_class_t;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
        alu_xor, alu_srl, alu_sra, alu_or, alu_and
    } alu_op_t;

    typedef enum logic [2:0] {
        st_fetch, st_fetch_wait, st_execute, st_mem, st_mem_wait, st_writeback
    } core_state_t;

endpackage

`default_nettype wire

// File: source/instr_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module instr_decode import core_pkg::*; (
    input  instr_t                instr,
    output logic [4:0]            rs1_idx,
    output logic [4:0]            rs2_idx,
    output logic [4:0]            rd_idx,
    output logic [`CORE_XLEN-1:0] imm,
    output instr_class_t          cls,
    output alu_op_t               alu_op,
    output logic                  uses_imm
);

    // funct3 plus the funct7 alternate bit
    function automatic alu_op_t funct_to_op(input logic [2:0] funct3, input logic alt);
        case (funct3)
            3'b000:  return alt ? alu_sub : alu_add;
            3'b001:  return alu_sll;
            3'b010:  return alu_slt;
            3'b011:  return alu_sltu;
            3'b100:  return alu_xor;
            3'b101:  return alt ? alu_sra : alu_srl;
            3'b110:  return alu_or;
            default: return alu_and;
        endcase
    endfunction

    // register fields sit at the same bits in every format
    assign rs1_idx = instr.r.rs1;
    assign rs2_idx = instr.r.rs2;
    assign rd_idx  = instr.r.rd;

    always_comb begin
        cls      = cls_nop;
        alu_op   = alu_add;
        uses_imm = 1'b0;
        imm      = '0;
        case (instr.r.opcode)
            op_lui: begin
                cls = cls_lui;
                imm = {instr.u.imm, 12'b0};
            end
            op_auipc: begin
                cls = cls_auipc;
                imm = {instr.u.imm, 12'b0};
            end
            op_jal: begin
                cls = cls_jal;
                imm = {{(`CORE_XLEN-21){instr.j.imm20}}, instr.j.imm20, instr.j.imm19_12,
                       instr.j.imm11, instr.j.imm10_1, 1'b0};
            end
            op_jalr: begin
                cls      = (instr.i.funct3 == 3'b000) ? cls_jalr : cls_nop;
                uses_imm = 1'b1;
                imm      = {{(`CORE_XLEN-12){instr.i.imm[11]}}, instr.i.imm};
            end
            op_branch: begin
                cls    = cls_branch;
                alu_op = alu_sub;
                imm    = {{(`CORE_XLEN-13){instr.b.imm12}}, instr.b.imm12, instr.b.imm11,
                          instr.b.imm10_5, instr.b.imm4_1, 1'b0};
            end
            // word access only, narrower widths fall through as nop
            op_load: begin
                cls      = (instr.i.funct3 == 3'b010) ? cls_load : cls_nop;
                uses_imm = 1'b1;
                imm      = {{(`CORE_XLEN-12){instr.i.imm[11]}}, instr.i.imm};
            end
            op_store: begin
                cls      = (instr.s.funct3 == 3'b010) ? cls_store : cls_nop;
                uses_imm = 1'b1;
                imm      = {{(`CORE_XLEN-12){instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
            end
            op_imm: begin
                cls      = cls_alu;
                uses_imm = 1'b1;
                alu_op   = funct_to_op(instr.i.funct3,
                                       (instr.i.funct3 == 3'b101) && instr.r.funct7[5]);
                // shifts take only shamt
                if (instr.i.funct3 == 3'b001 || instr.i.funct3 == 3'b101) begin
                    imm = {{(`CORE_XLEN-5){1'b0}}, instr.i.imm[4:0]};
                end else begin
                    imm = {{(`CORE_XLEN-12){instr.i.imm[11]}}, instr.i.imm};
                end
            end
            op_reg: begin
                cls    = cls_alu;
                alu_op = funct_to_op(instr.r.funct3, instr.r.funct7[5]);
            end
            op_fence, op_system: cls = cls_nop;
            default: cls = cls_nop;
        endcase
    end

endmodule

`default_nettype wire

// File: source/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module reg_file (
    input  logic                  clk_cpu,
    input  logic                  arst_n,
    input  logic [4:0]            rs1_idx,
    input  logic [4:0]            rs2_idx,
    input  logic [4:0]            rd_idx,
    input  logic                  wen,
    input  logic [`CORE_XLEN-1:0] rd_data,
    output logic [`CORE_XLEN-1:0] rs1_data,
    output logic [`CORE_XLEN-1:0] rs2_data
);

    // x0 has no storage
    logic [`CORE_XLEN-1:0] regs [1:`CORE_NREGS-1];

    always_ff @(posedge clk_cpu or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < `CORE_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && rd_idx != 5'd0) begin
            regs[rd_idx] <= rd_data;
        end
    end

    assign rs1_data = (rs1_idx == 5'd0) ? '0 : regs[rs1_idx];
    assign rs2_data = (rs2_idx == 5'd0) ? '0 : regs[rs2_idx];

endmodule

`default_nettype wire

// File: source/alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module alu import core_pkg::*; (
    input  logic [`CORE_XLEN-1:0] a,
    input  logic [`CORE_XLEN-1:0] b,
    input  alu_op_t               op,
    output logic [`CORE_XLEN-1:0] result,
    output logic                  eq,
    output logic                  lt,
    output logic                  ltu
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    // compare flags, independent of op
    assign eq  = (a == b);
    assign lt  = ($signed(a) < $signed(b));
    assign ltu = (a < b);

    always_comb begin
        case (op)
            alu_add:  result = a + b;
            alu_sub:  result = a - b;
            alu_sll:  result = a << shamt;
            alu_slt:  result = {{(`CORE_XLEN-1){1'b0}}, lt};
            alu_sltu: result = {{(`CORE_XLEN-1){1'b0}}, ltu};
            alu_xor:  result = a ^ b;
            alu_srl:  result = a >> shamt;
            alu_sra:  result = $signed(a) >>> shamt;
            alu_or:   result = a | b;
            alu_and:  result = a & b;
            default:  result = a + b;
        endcase
    end

endmodule

`default_nettype wire

// File: core/core_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module core_ctrl import core_pkg::*; (
    input  logic                  clk_cpu,
    input  logic                  arst_n,
    input  logic                  mem_ready,
    input  logic [`CORE_XLEN-1:0] mem_rdata,
    output logic                  mem_req,
    output logic                  mem_we,
    output logic [`CORE_XLEN-1:0] mem_addr,
    output logic [`CORE_XLEN-1:0] mem_wdata,
    output instr_t                instr,
    input  instr_class_t          cls,
    input  logic [`CORE_XLEN-1:0] imm,
    input  alu_op_t               dec_alu_op,
    input  logic                  uses_imm,
    input  logic [`CORE_XLEN-1:0] rs1_data,
    input  logic [`CORE_XLEN-1:0] rs2_data,
    output logic [`CORE_XLEN-1:0] alu_a,
    output logic [`CORE_XLEN-1:0] alu_b,
    output alu_op_t               alu_op,
    input  logic [`CORE_XLEN-1:0] alu_result,
    input  logic                  alu_eq,
    input  logic                  alu_lt,
    input  logic                  alu_ltu,
    output logic                  rd_wen,
    output logic [`CORE_XLEN-1:0] rd_data
);

    core_state_t           state;
    logic [`CORE_XLEN-1:0] pc;
    logic [`CORE_XLEN-1:0] pc_next_q;
    logic [`CORE_XLEN-1:0] alu_res_q;
    logic [`CORE_XLEN-1:0] load_q;
    logic [`CORE_XLEN-1:0] pc_plus4;
    logic [`CORE_XLEN-1:0] pc_plus_imm;
    logic [`CORE_XLEN-1:0] pc_target;
    logic                  br_taken;
    logic                  is_mem;

    // ==================================================================
    // operand select and next pc
    // ==================================================================

    assign alu_a       = rs1_data;
    assign alu_b       = uses_imm ? imm : rs2_data;
    assign alu_op      = dec_alu_op;
    assign pc_plus4    = pc + 4;
    assign pc_plus_imm = pc + imm;
    assign is_mem      = (cls == cls_load) || (cls == cls_store);

    always_comb begin
        case (instr.b.funct3)
            3'b000:  br_taken = alu_eq;
            3'b001:  br_taken = !alu_eq;
            3'b100:  br_taken = alu_lt;
            3'b101:  br_taken = !alu_lt;
            3'b110:  br_taken = alu_ltu;
            3'b111:  br_taken = !alu_ltu;
            default: br_taken = 1'b0;
        endcase
    end

    always_comb begin
        case (cls)
            cls_jal:    pc_target = pc_plus_imm;
            cls_jalr:   pc_target = {alu_result[`CORE_XLEN-1:1], 1'b0};
            cls_branch: pc_target = br_taken ? pc_plus_imm : pc_plus4;
            default:    pc_target = pc_plus4;
        endcase
    end

    // write-back source
    always_comb begin
        case (cls)
            cls_lui:           rd_data = imm;
            cls_auipc:         rd_data = pc_plus_imm;
            cls_jal, cls_jalr: rd_data = pc_plus4;
            cls_load:          rd_data = load_q;
            default:           rd_data = alu_res_q;
        endcase
    end

    assign rd_wen = (state == st_writeback) && !(cls inside {cls_branch, cls_store, cls_nop});

    // ==================================================================
    // fsm and bus strobes
    // ==================================================================

    always_ff @(posedge clk_cpu or negedge arst_n) begin
        if (!arst_n) begin
            state   <= st_fetch;
            pc      <= `CORE_RESET_PC;
            mem_req <= 1'b0;
            mem_we  <= 1'b0;
        end else begin
            case (state)
                st_fetch: begin
                    mem_req <= 1'b1;
                    mem_we  <= 1'b0;
                    state   <= st_fetch_wait;
                end
                st_fetch_wait: begin
                    mem_req <= 1'b0;
                    if (mem_ready) state <= st_execute;
                end
                st_execute: state <= is_mem ? st_mem : st_writeback;
                st_mem: begin
                    mem_req <= 1'b1;
                    mem_we  <= (cls == cls_store);
                    state   <= st_mem_wait;
                end
                st_mem_wait: begin
                    mem_req <= 1'b0;
                    if (mem_ready) state <= st_writeback;
                end
                st_writeback: begin
                    pc    <= pc_next_q;
                    state <= st_fetch;
                end
                default: state <= st_fetch;
            endcase
        end
    end

    // payload, held until the next load
    always_ff @(posedge clk_cpu) begin
        case (state)
            st_fetch: mem_addr <= pc;
            st_fetch_wait: if (mem_ready) instr <= mem_rdata;
            st_execute: begin
                alu_res_q <= alu_result;
                pc_next_q <= pc_target;
            end
            st_mem: begin
                mem_addr  <= {alu_res_q[`CORE_XLEN-1:2], 2'b00};
                mem_wdata <= rs2_data;
            end
            st_mem_wait: if (mem_ready) load_q <= mem_rdata;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: core/core_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module core_top import core_pkg::*; (
    input  logic                  clk_cpu,
    input  logic                  arst_n,
    input  logic                  mem_ready,
    input  logic [`CORE_XLEN-1:0] mem_rdata,
    output logic                  mem_req,
    output logic                  mem_we,
    output logic [`CORE_XLEN-1:0] mem_addr,
    output logic [`CORE_XLEN-1:0] mem_wdata
);

    instr_t                instr;
    instr_class_t          cls;
    alu_op_t               dec_alu_op;
    alu_op_t               alu_op;
    logic [`CORE_XLEN-1:0] imm;
    logic                  uses_imm;
    logic [4:0]            rs1_idx;
    logic [4:0]            rs2_idx;
    logic [4:0]            rd_idx;
    logic [`CORE_XLEN-1:0] rs1_data;
    logic [`CORE_XLEN-1:0] rs2_data;
    logic                  rd_wen;
    logic [`CORE_XLEN-1:0] rd_data;
    logic [`CORE_XLEN-1:0] alu_a;
    logic [`CORE_XLEN-1:0] alu_b;
    logic [`CORE_XLEN-1:0] alu_result;
    logic                  alu_eq;
    logic                  alu_lt;
    logic                  alu_ltu;

    core_ctrl i_core_ctrl (
        .clk_cpu(clk_cpu), .arst_n(arst_n),
        .mem_ready(mem_ready), .mem_rdata(mem_rdata), .mem_req(mem_req),
        .mem_we(mem_we), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
        .instr(instr), .cls(cls), .imm(imm), .dec_alu_op(dec_alu_op),
        .uses_imm(uses_imm), .rs1_data(rs1_data), .rs2_data(rs2_data),
        .alu_a(alu_a), .alu_b(alu_b), .alu_op(alu_op), .alu_result(alu_result),
        .alu_eq(alu_eq), .alu_lt(alu_lt), .alu_ltu(alu_ltu),
        .rd_wen(rd_wen), .rd_data(rd_data)
    );

    instr_decode i_instr_decode (
        .instr(instr), .rs1_idx(rs1_idx), .rs2_idx(rs2_idx), .rd_idx(rd_idx),
        .imm(imm), .cls(cls), .alu_op(dec_alu_op), .uses_imm(uses_imm)
    );

    reg_file i_reg_file (
        .clk_cpu(clk_cpu), .arst_n(arst_n), .rs1_idx(rs1_idx), .rs2_idx(rs2_idx),
        .rd_idx(rd_idx), .wen(rd_wen), .rd_data(rd_data),
        .rs1_data(rs1_data), .rs2_data(rs2_data)
    );

    alu i_alu (
        .a(alu_a), .b(alu_b), .op(alu_op), .result(alu_result),
        .eq(alu_eq), .lt(alu_lt), .ltu(alu_ltu)
    );

endmodule

`default_nettype wire

// File: dv/tb_mem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem (
    input  logic        clk_cpu,
    input  logic        mem_req,
    input  logic        mem_we,
    input  logic [31:0] mem_addr,
    input  logic [31:0] mem_wdata,
    output logic        mem_ready,
    output logic [31:0] mem_rdata
);

    logic [31:0] mem [0:255];
    logic [7:0]  pend_idx;
    logic        pending = 1'b0;
    logic [1:0]  wait_cnt;
    logic [31:0] rnd;
    int          seed = 53;
    int          wr_idx = 0;

    // ==================================================================
    // rv32i encoders
    // ==================================================================

    function automatic logic [31:0] r_type(input int f7, input int f3, input int rd,
                                           input int rs1, input int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
    endfunction

    function automatic logic [31:0] i_type(input int op, input int f3, input int rd,
                                           input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
    endfunction

    function automatic logic [31:0] s_type(input int rs1, input int rs2, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] b_type(input int f3, input int rs1, input int rs2,
                                           input int imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] u_type(input int op, input int rd, input int imm);
        return {imm[19:0], rd[4:0], op[6:0]};
    endfunction

    function automatic logic [31:0] j_type(input int rd, input int imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6F};
    endfunction

    task automatic put(input logic [31:0] word);
        mem[wr_idx] = word;
        wr_idx = wr_idx + 1;
    endtask

    // ==================================================================
    // test program
    // ==================================================================

    initial begin
        mem_ready = 1'b0;
        mem_rdata = '0;
        for (int a = 0; a < 256; a++) begin
            mem[a] = 32'hDEAD_0000 ^ (a << 2);
        end
        // x31 store base, x1 = -8, x2 = 3, x9 poison
        put(i_type('h13, 0, 31, 0, 512));
        put(i_type('h13, 0, 1, 0, -8));
        put(i_type('h13, 0, 2, 0, 3));
        put(i_type('h13, 0, 9, 0, 'h5AD));
        // alu results to 0x200..0x22c
        put(r_type(0, 0, 3, 1, 2));
        put(s_type(31, 3, 0));
        put(r_type('h20, 0, 3, 2, 1));
        put(s_type(31, 3, 4));
        put(r_type(0, 1, 3, 2, 2));
        put(s_type(31, 3, 8));
        put(r_type(0, 2, 3, 1, 2));
        put(s_type(31, 3, 12));
        put(r_type(0, 3, 3, 1, 2));
        put(s_type(31, 3, 16));
        put(i_type('h13, 4, 3, 1, 'hF0));
        put(s_type(31, 3, 20));
        put(i_type('h13, 5, 3, 1, 'h402));
        put(s_type(31, 3, 24));
        put(i_type('h13, 5, 3, 1, 28));
        put(s_type(31, 3, 28));
        put(i_type('h13, 6, 3, 2, 'h40));
        put(s_type(31, 3, 32));
        put(i_type('h13, 7, 3, 1, 'hFF));
        put(s_type(31, 3, 36));
        put(i_type('h13, 3, 3, 2, -1));
        put(s_type(31, 3, 40));
        put(i_type('h13, 2, 3, 2, -1));
        put(s_type(31, 3, 44));
        // upper immediates and jumps, pc 112
        put(u_type('h37, 4, 'h12345));
        put(s_type(31, 4, 48));
        put(u_type('h17, 4, 1));
        put(s_type(31, 4, 52));
        put(j_type(5, 8));
        put(s_type(31, 9, 0));
        put(s_type(31, 5, 56));
        // odd target so the low bit gets cleared
        put(i_type('h67, 0, 6, 0, 149));
        put(s_type(31, 9, 0));
        put(s_type(31, 6, 60));
        // each condition not taken, then taken over a poison store
        for (int f = 0; f < 8; f++) begin
            if (f != 2 && f != 3) begin
                put(b_type(f, (f == 0 || f == 5 || f == 6) ? 1 : 2,
                           (f == 0 || f == 5 || f == 6) ? 2 : ((f == 1) ? 2 : 1), 8));
                put(b_type(f, (f == 0 || f == 4 || f == 7) ? ((f == 0) ? 2 : 1) : 2,
                           (f == 0 || f == 4 || f == 7) ? 2 : 1, 8));
                put(s_type(31, 9, 0));
            end
        end
        put(i_type('h13, 0, 10, 0, 'h123));
        put(s_type(31, 10, 64));
        // memory round trip and x0
        put(s_type(31, 2, 68));
        put(i_type('h03, 2, 7, 31, 68));
        put(i_type('h13, 0, 7, 7, 1));
        put(s_type(31, 7, 72));
        put(i_type('h13, 0, 0, 0, 55));
        put(s_type(31, 0, 76));
        put(j_type(0, 0));
    end

    // writes land at the strobe and reads return with the ready pulse
    always @(posedge clk_cpu) begin
        mem_ready <= 1'b0;
        if (mem_req) begin
            rnd = $random(seed);
            if (mem_we) begin
                mem[mem_addr[9:2]] <= mem_wdata;
            end
            if (rnd[1:0] == 2'd0) begin
                mem_ready <= 1'b1;
                mem_rdata <= mem[mem_addr[9:2]];
            end else begin
                pend_idx <= mem_addr[9:2];
                pending  <= 1'b1;
                wait_cnt <= rnd[1:0] - 2'd1;
            end
        end else if (pending) begin
            if (wait_cnt == 2'd0) begin
                mem_ready <= 1'b1;
                mem_rdata <= mem[pend_idx];
                pending   <= 1'b0;
            end else begin
                wait_cnt <= wait_cnt - 2'd1;
            end
        end
    end

endmodule

`default_nettype wire

// File: dv/tb_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module tb_core;

    localparam int          n_stores    = 20;
    localparam int          cycle_limit = 1000;
    localparam logic [31:0] poison      = 32'h0000_05AD;
    localparam logic [31:0] halt_addr   = 32'h0000_0100;

    logic        clk_cpu = 1'b0;
    logic        arst_n = 1'b0;
    logic        mem_req;
    logic        mem_we;
    logic        mem_ready;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic [31:0] mem_rdata;

    logic [31:0] exp_addr [0:n_stores-1];
    logic [31:0] exp_val [0:n_stores-1];
    int          exp_test [0:n_stores-1];
    logic        test_bad [1:6] = '{default: 1'b0};
    int          idx = 0;
    int          cycles = 0;
    int          passed = 0;
    int          failed = 0;
    int          halt_fetches = 0;
    logic        outstanding = 1'b0;
    logic        req_prev = 1'b0;
    logic        seen_first = 1'b0;

    core_top i_core_top (
        .clk_cpu(clk_cpu), .arst_n(arst_n), .mem_ready(mem_ready), .mem_rdata(mem_rdata),
        .mem_req(mem_req), .mem_we(mem_we), .mem_addr(mem_addr), .mem_wdata(mem_wdata)
    );

    tb_mem i_tb_mem (
        .clk_cpu(clk_cpu), .mem_req(mem_req), .mem_we(mem_we), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_ready(mem_ready), .mem_rdata(mem_rdata)
    );

    always #5 clk_cpu = ~clk_cpu;

    task automatic expect_store(input logic [31:0] addr, input logic [31:0] val, input int t);
        exp_addr[idx] = addr;
        exp_val[idx]  = val;
        exp_test[idx] = t;
        idx = idx + 1;
    endtask

    task automatic report_test(input int t);
        if (test_bad[t]) begin
            $display("test %0d failed", t);
            failed = failed + 1;
        end else begin
            $display("test %0d passed", t);
            passed = passed + 1;
        end
    endtask

    task automatic check_store();
        assert (mem_wdata != poison) else begin
            $display("%0t: store carried the poison value, a branch went the wrong way", $time);
            test_bad[5] = 1'b1;
        end
        if (mem_wdata != poison) begin
            if (idx >= n_stores) begin
                $display("%0t: store to %h after the last expected one", $time, mem_addr);
                failed = failed + 1;
            end else begin
                assert (mem_addr == exp_addr[idx]) else begin
                    $display("MISMATCH %0t mem_addr expected %h actual %h",
                             $time, exp_addr[idx], mem_addr);
                    test_bad[exp_test[idx]] = 1'b1;
                end
                assert (mem_wdata == exp_val[idx]) else begin
                    $display("MISMATCH %0t mem_wdata expected %h actual %h",
                             $time, exp_val[idx], mem_wdata);
                    test_bad[exp_test[idx]] = 1'b1;
                end
                if (idx == n_stores - 1 || exp_test[idx + 1] != exp_test[idx]) begin
                    report_test(exp_test[idx]);
                end
                idx = idx + 1;
            end
        end
    endtask

    // ==================================================================
    // bus monitor
    // ==================================================================

    always @(posedge clk_cpu) begin
        cycles <= cycles + 1;
        if (!arst_n) begin
            assert (!mem_req) else begin
                $display("%0t: mem_req raised while reset was held", $time);
                test_bad[1] = 1'b1;
            end
        end else if (mem_req) begin
            if (!seen_first) begin
                assert (mem_addr == `CORE_RESET_PC) else begin
                    $display("MISMATCH %0t mem_addr expected %h actual %h",
                             $time, `CORE_RESET_PC, mem_addr);
                    test_bad[1] = 1'b1;
                end
                assert (!mem_we) else begin
                    $display("%0t: first bus request after reset was a write", $time);
                    test_bad[1] = 1'b1;
                end
                seen_first <= 1'b1;
            end
            // terminal jump to itself at the end of the program
            if (!mem_we && mem_addr == halt_addr) begin
                halt_fetches <= halt_fetches + 1;
            end
            assert (!outstanding) else begin
                $display("%0t: new request issued before the previous ready", $time);
                test_bad[2] = 1'b1;
            end
            assert (!req_prev) else begin
                $display("%0t: mem_req held high for two cycles", $time);
                test_bad[2] = 1'b1;
            end
            if (mem_we) begin
                check_store();
            end
        end
        req_prev <= mem_req;
        if (mem_req) begin
            outstanding <= 1'b1;
        end else if (mem_ready) begin
            outstanding <= 1'b0;
        end
    end

    initial begin
        // alu results
        expect_store(32'h200, 32'hFFFF_FFFB, 3);
        expect_store(32'h204, 32'h0000_000B, 3);
        expect_store(32'h208, 32'h0000_0018, 3);
        expect_store(32'h20C, 32'h0000_0001, 3);
        expect_store(32'h210, 32'h0000_0000, 3);
        expect_store(32'h214, 32'hFFFF_FF08, 3);
        expect_store(32'h218, 32'hFFFF_FFFE, 3);
        expect_store(32'h21C, 32'h0000_000F, 3);
        expect_store(32'h220, 32'h0000_0043, 3);
        expect_store(32'h224, 32'h0000_00F8, 3);
        expect_store(32'h228, 32'h0000_0001, 3);
        expect_store(32'h22C, 32'h0000_0000, 3);
        // lui, auipc at pc 120, jal link from 128, jalr link from 140
        expect_store(32'h230, 32'h1234_5000, 4);
        expect_store(32'h234, 32'h0000_1078, 4);
        expect_store(32'h238, 32'h0000_0084, 4);
        expect_store(32'h23C, 32'h0000_0090, 4);
        expect_store(32'h240, 32'h0000_0123, 5);
        expect_store(32'h244, 32'h0000_0003, 6);
        expect_store(32'h248, 32'h0000_0004, 6);
        expect_store(32'h24C, 32'h0000_0000, 6);
        idx = 0;
        repeat (4) @(posedge clk_cpu);
        arst_n <= 1'b1;
        while ((idx < n_stores || halt_fetches < 2) && cycles < cycle_limit) begin
            @(posedge clk_cpu);
        end
        if (idx < n_stores || halt_fetches < 2) begin
            $display("timeout, the program did not finish within %0d cycles", cycle_limit);
        end
        report_test(1);
        report_test(2);
        $display("tests passed %0d, failed %0d", passed, failed);
        if (failed == 0 && idx == n_stores && halt_fetches >= 2) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+common
common/core_pkg.sv
source/instr_decode.sv
source/reg_file.sv
source/alu.sv
core/core_ctrl.sv
core/core_top.sv
dv/tb_mem.sv
dv/tb_core.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build output"

test:
	verilator --binary --timing --assert -f list.f --top-module tb_core -o sim_core
	./obj_dir/sim_core | tee /dev/stderr | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir
